//--- logic/wbPkg.sv
package wbPkg;

        // ------------------------------------------------------------------------
        // Core sizes
        // ------------------------------------------------------------------------
        localparam int CHECKPOINTS     = 8;         // One mask bit per checkpoint
        localparam int CHECKPOINTS_LOG = 3;
        localparam int AL_LOG          = 6;         // Active list tag
        localparam int PHYS_LOG        = 7;         // Physical register number
        localparam int DATA_WIDTH      = 32;
        localparam int PC_WIDTH        = 24;

        // ------------------------------------------------------------------------
        // Packet from execute
        // ------------------------------------------------------------------------
        typedef struct packed {
                logic writesReg;
                logic isBranch;
        } execFlags_t;

        // How lane 1 sees the result word of a branch
        typedef struct packed {
                logic [PC_WIDTH-1:0]        target;
                logic                       actualTaken;
                logic                       predTaken;
                logic [CHECKPOINTS_LOG-1:0] checkpointId;
                logic [2:0]                 spare;
        } ctrlView_t;

        // Branches use ctrl, everything else (links too) uses data
        typedef union packed {
                logic [DATA_WIDTH-1:0] data;
                ctrlView_t             ctrl;
        } wbPayload_u;

        typedef struct packed {
                logic [CHECKPOINTS-1:0] branchMask;  // Unresolved older branches
                execFlags_t             flags;
                logic [AL_LOG-1:0]      alTag;
                logic [PHYS_LOG-1:0]    physDest;
                wbPayload_u             payload;
        } exePacket_t;

endpackage

//--- logic/wbIfs.sv
// Lane 1 registered packet as seen by the branch resolver
interface resolveIf import wbPkg::*; ();

        logic                   valid;
        logic                   isBranch;
        wbPayload_u             payload;
        logic [CHECKPOINTS-1:0] branchMask;

        modport lane
        (
                output valid,
                output isBranch,
                output payload,
                output branchMask
        );

        modport resolver
        (
                input  valid,
                input  isBranch,
                input  payload,
                input  branchMask
        );

endinterface

// Mispredict notice and the resulting kill mask
interface recoveryIf import wbPkg::*; ();

        logic                       mispredict;
        logic [CHECKPOINTS_LOG-1:0] checkpointId;
        logic [CHECKPOINTS-1:0]     killMask;
        logic                       flushActive;

        modport resolver (output mispredict, output checkpointId);

        modport ctrl (input mispredict, input checkpointId, output killMask, output flushActive);

        modport lane (input killMask);

endinterface

//--- logic/flushTimer.sv
module flushTimer
#(
        parameter int FLUSH_CYCLES = 4
)
(
        input  logic clk,
        input  logic reset,
        input  logic load_i,
        output logic expired_o
);

        localparam int CNT_W = $clog2(FLUSH_CYCLES + 1);

        logic [CNT_W-1:0] count;

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        count <= '0;
                end
                else if (load_i)
                begin
                        count <= CNT_W'(FLUSH_CYCLES);
                end
                else if (count != '0)
                begin
                        count <= count - CNT_W'(1);
                end
        end

        // Last cycle of the window
        assign expired_o = (count == CNT_W'(1)) & ~load_i;

endmodule

//--- logic/recoveryCtrl.sv
module recoveryCtrl import wbPkg::*;
#(
        parameter int FLUSH_CYCLES = 4
)
(
        input  logic    clk,
        input  logic    reset,
        recoveryIf.ctrl recovery
);

        localparam logic STATE_IDLE  = 1'b0;
        localparam logic STATE_FLUSH = 1'b1;

        logic                   state;
        logic                   stateNext;
        logic [CHECKPOINTS-1:0] flushMask;
        logic [CHECKPOINTS-1:0] flushMaskNext;
        logic [CHECKPOINTS-1:0] newBit;
        logic                   timerExpired;

        assign newBit = recovery.mispredict ? (CHECKPOINTS'(1) << recovery.checkpointId) : '0;

        // ------------------------------------------------------------------------
        // Next state
        // ------------------------------------------------------------------------
        always_comb
        begin
                stateNext     = state;
                flushMaskNext = flushMask;
                case (state)
                        STATE_IDLE:
                        begin
                                if (recovery.mispredict)
                                begin
                                        stateNext     = STATE_FLUSH;
                                        flushMaskNext = newBit;
                                end
                        end
                        default:
                        begin
                                if (recovery.mispredict)
                                begin
                                        flushMaskNext = flushMask | newBit;    // Window restarts
                                end
                                else if (timerExpired)
                                begin
                                        stateNext     = STATE_IDLE;
                                        flushMaskNext = '0;
                                end
                        end
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        state     <= STATE_IDLE;
                        flushMask <= '0;
                end
                else
                begin
                        state     <= stateNext;
                        flushMask <= flushMaskNext;
                end
        end

        flushTimer #(
                .FLUSH_CYCLES (FLUSH_CYCLES)
        ) uFlushTimer (
                .clk       (clk),
                .reset     (reset),
                .load_i    (recovery.mispredict),
                .expired_o (timerExpired)
        );

        // Current mispredict kills in its own cycle
        assign recovery.killMask    = flushMask | newBit;
        assign recovery.flushActive = (state == STATE_FLUSH);

endmodule

//--- logic/branchResolve.sv
module branchResolve import wbPkg::*;
(
        resolveIf.resolver                  resolve,
        recoveryIf.resolver                 recovery,

        output logic                        ctrlVerified_o,
        output logic                        ctrlMispredict_o,
        output logic [CHECKPOINTS_LOG-1:0]  ctrlCheckpoint_o,
        output logic [PC_WIDTH-1:0]         ctrlTarget_o,
        output logic                        ctrlTaken_o
);

        ctrlView_t ctrlView;
        logic      selfDependent;
        logic      verified;
        logic      mispredict;

        // Branch view of the result word
        assign ctrlView = resolve.payload.ctrl;

        // A well formed branch never waits on its own checkpoint
        assign selfDependent = resolve.branchMask[ctrlView.checkpointId];

        // ------------------------------------------------------------------------
        // Direction check
        // ------------------------------------------------------------------------
        assign verified   = resolve.valid & resolve.isBranch & ~selfDependent;
        assign mispredict = verified & (ctrlView.actualTaken ^ ctrlView.predTaken);

        assign ctrlVerified_o   = verified;
        assign ctrlMispredict_o = mispredict;
        assign ctrlCheckpoint_o = ctrlView.checkpointId;
        assign ctrlTarget_o     = ctrlView.target;
        assign ctrlTaken_o      = ctrlView.actualTaken;        // Resolved direction

        // To the recovery controller
        assign recovery.mispredict   = mispredict;
        assign recovery.checkpointId = ctrlView.checkpointId;

endmodule

//--- logic/wbLane.sv
module wbLane import wbPkg::*;
#(
        parameter bit HAS_RESOLVE = 1'b0
)
(
        input  logic                  clk,
        input  logic                  reset,

        input  logic                  exeValid_i,
        input  exePacket_t            exePacket_i,

        resolveIf.lane                resolve,
        recoveryIf.lane               recovery,

        output logic                  wbValid_o,
        output logic [AL_LOG-1:0]     wbTag_o,
        output logic                  bypassValid_o,
        output logic [PHYS_LOG-1:0]   bypassDest_o,
        output logic [DATA_WIDTH-1:0] bypassData_o
);

        logic       validQ;
        exePacket_t packetQ;
        logic       killed;

        // ------------------------------------------------------------------------
        // Pipeline register
        // ------------------------------------------------------------------------
        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        validQ <= 1'b0;
                end
                else
                begin
                        validQ <= exeValid_i;
                end
        end

        always_ff @(posedge clk)
        begin
                if (exeValid_i)
                begin
                        packetQ <= exePacket_i;         // Hold last packet otherwise
                end
        end

        // ------------------------------------------------------------------------
        // Kill test and writeback formatting
        // ------------------------------------------------------------------------
        assign killed = |(packetQ.branchMask & recovery.killMask);

        assign wbValid_o     = validQ & ~killed;
        assign wbTag_o       = packetQ.alTag;

        assign bypassValid_o = wbValid_o & packetQ.flags.writesReg;
        assign bypassDest_o  = packetQ.physDest;
        assign bypassData_o  = packetQ.payload.data;    // Result or link value

        // Only the branch lane talks to the resolver
        generate
                if (HAS_RESOLVE)
                begin : genResolve
                        assign resolve.valid      = validQ;
                        assign resolve.isBranch   = packetQ.flags.isBranch;
                        assign resolve.payload    = packetQ.payload;
                        assign resolve.branchMask = packetQ.branchMask;
                end
                else
                begin : genNoResolve
                        assign resolve.valid      = 1'b0;
                        assign resolve.isBranch   = 1'b0;
                        assign resolve.payload    = '0;
                        assign resolve.branchMask = '0;
                end
        endgenerate

endmodule

//--- logic/writebackStage.sv
module writebackStage import wbPkg::*;
#(
        parameter int FLUSH_CYCLES = 4
)
(
        input  logic                       clk,
        input  logic                       reset,

        input  logic                       exeValid0_i,
        input  exePacket_t                 exePacket0_i,
        input  logic                       exeValid1_i,
        input  exePacket_t                 exePacket1_i,
        input  logic                       exeValid2_i,
        input  exePacket_t                 exePacket2_i,

        output logic                       wbValid0_o,
        output logic [AL_LOG-1:0]          wbTag0_o,
        output logic                       bypassValid0_o,
        output logic [PHYS_LOG-1:0]        bypassDest0_o,
        output logic [DATA_WIDTH-1:0]      bypassData0_o,

        output logic                       wbValid1_o,
        output logic [AL_LOG-1:0]          wbTag1_o,
        output logic                       bypassValid1_o,
        output logic [PHYS_LOG-1:0]        bypassDest1_o,
        output logic [DATA_WIDTH-1:0]      bypassData1_o,

        output logic                       wbValid2_o,
        output logic [AL_LOG-1:0]          wbTag2_o,
        output logic                       bypassValid2_o,
        output logic [PHYS_LOG-1:0]        bypassDest2_o,
        output logic [DATA_WIDTH-1:0]      bypassData2_o,

        output logic                       ctrlVerified_o,
        output logic                       ctrlMispredict_o,
        output logic [CHECKPOINTS_LOG-1:0] ctrlCheckpoint_o,
        output logic [PC_WIDTH-1:0]        ctrlTarget_o,
        output logic                       ctrlTaken_o,
        output logic                       flushActive_o
);

        resolveIf  resolveBus ();
        resolveIf  resolveUnused0 ();       // Lanes 0 and 2 hold these at zero
        resolveIf  resolveUnused2 ();
        recoveryIf recoveryBus ();

        // ------------------------------------------------------------------------
        // Execute lanes
        // ------------------------------------------------------------------------
        wbLane #(.HAS_RESOLVE (1'b0)) uLane0 (
                .clk           (clk),
                .reset         (reset),
                .exeValid_i    (exeValid0_i),
                .exePacket_i   (exePacket0_i),
                .resolve       (resolveUnused0.lane),
                .recovery      (recoveryBus.lane),
                .wbValid_o     (wbValid0_o),
                .wbTag_o       (wbTag0_o),
                .bypassValid_o (bypassValid0_o),
                .bypassDest_o  (bypassDest0_o),
                .bypassData_o  (bypassData0_o)
        );

        wbLane #(.HAS_RESOLVE (1'b1)) uLane1 (          // Branch ALU
                .clk           (clk),
                .reset         (reset),
                .exeValid_i    (exeValid1_i),
                .exePacket_i   (exePacket1_i),
                .resolve       (resolveBus.lane),
                .recovery      (recoveryBus.lane),
                .wbValid_o     (wbValid1_o),
                .wbTag_o       (wbTag1_o),
                .bypassValid_o (bypassValid1_o),
                .bypassDest_o  (bypassDest1_o),
                .bypassData_o  (bypassData1_o)
        );

        wbLane #(.HAS_RESOLVE (1'b0)) uLane2 (          // Load unit
                .clk           (clk),
                .reset         (reset),
                .exeValid_i    (exeValid2_i),
                .exePacket_i   (exePacket2_i),
                .resolve       (resolveUnused2.lane),
                .recovery      (recoveryBus.lane),
                .wbValid_o     (wbValid2_o),
                .wbTag_o       (wbTag2_o),
                .bypassValid_o (bypassValid2_o),
                .bypassDest_o  (bypassDest2_o),
                .bypassData_o  (bypassData2_o)
        );

        // ------------------------------------------------------------------------
        // Branch resolution and recovery
        // ------------------------------------------------------------------------
        branchResolve uBranchResolve (
                .resolve          (resolveBus.resolver),
                .recovery         (recoveryBus.resolver),
                .ctrlVerified_o   (ctrlVerified_o),
                .ctrlMispredict_o (ctrlMispredict_o),
                .ctrlCheckpoint_o (ctrlCheckpoint_o),
                .ctrlTarget_o     (ctrlTarget_o),
                .ctrlTaken_o      (ctrlTaken_o)
        );

        recoveryCtrl #(
                .FLUSH_CYCLES (FLUSH_CYCLES)
        ) uRecoveryCtrl (
                .clk      (clk),
                .reset    (reset),
                .recovery (recoveryBus.ctrl)
        );

        assign flushActive_o = recoveryBus.flushActive;

endmodule

//--- bench/writebackStage_assert.sv
module writebackStage_assert import wbPkg::*;
#(
        parameter int FLUSH_CYCLES = 4
)
(
        input logic                       clk,
        input logic                       reset,
        input logic                       exeValid0_i,
        input exePacket_t                 exePacket0_i,
        input logic                       exeValid1_i,
        input exePacket_t                 exePacket1_i,
        input logic                       exeValid2_i,
        input exePacket_t                 exePacket2_i,
        input logic                       wbValid0_o,
        input logic [AL_LOG-1:0]          wbTag0_o,
        input logic                       bypassValid0_o,
        input logic [PHYS_LOG-1:0]        bypassDest0_o,
        input logic [DATA_WIDTH-1:0]      bypassData0_o,
        input logic                       wbValid1_o,
        input logic [AL_LOG-1:0]          wbTag1_o,
        input logic                       bypassValid1_o,
        input logic [PHYS_LOG-1:0]        bypassDest1_o,
        input logic [DATA_WIDTH-1:0]      bypassData1_o,
        input logic                       wbValid2_o,
        input logic [AL_LOG-1:0]          wbTag2_o,
        input logic                       bypassValid2_o,
        input logic [PHYS_LOG-1:0]        bypassDest2_o,
        input logic [DATA_WIDTH-1:0]      bypassData2_o,
        input logic                       ctrlVerified_o,
        input logic                       ctrlMispredict_o,
        input logic [CHECKPOINTS_LOG-1:0] ctrlCheckpoint_o,
        input logic [PC_WIDTH-1:0]        ctrlTarget_o,
        input logic                       ctrlTaken_o,
        input logic                       flushActive_o
);

        logic                   resetSeen;             // Reset sampled at previous edge
        logic                   prevValid [3];
        exePacket_t             prevPkt [3];
        logic [CHECKPOINTS-1:0] modelFlush;
        int                     modelCount;
        logic [CHECKPOINTS-1:0] curBit;
        logic [CHECKPOINTS-1:0] modelKill;
        logic                   pass [3];
        logic                   drop [3];
        ctrlView_t              prevCtrl;
        int                     errorCount = 0;        // Failed checks so far

        // ------------------------------------------------------------------------
        // Reference of what entered each lane and of the flush window
        // ------------------------------------------------------------------------
        assign curBit    = ctrlMispredict_o ? (CHECKPOINTS'(1) << ctrlCheckpoint_o) : '0;
        assign modelKill = modelFlush | curBit;
        assign prevCtrl  = prevPkt[1].payload.ctrl;

        always_ff @(posedge clk)
        begin
                resetSeen  <= reset;
                prevValid[0] <= reset ? 1'b0 : exeValid0_i;
                prevValid[1] <= reset ? 1'b0 : exeValid1_i;
                prevValid[2] <= reset ? 1'b0 : exeValid2_i;
                prevPkt[0] <= exePacket0_i;
                prevPkt[1] <= exePacket1_i;
                prevPkt[2] <= exePacket2_i;
                if (reset)
                begin
                        modelFlush <= '0;
                        modelCount <= 0;
                end
                else if (ctrlMispredict_o)
                begin
                        modelFlush <= modelFlush | curBit;
                        modelCount <= FLUSH_CYCLES;    // Full window again
                end
                else if (modelCount != 0)
                begin
                        modelCount <= modelCount - 1;
                        if (modelCount == 1)
                        begin
                                modelFlush <= '0;
                        end
                end
        end

        always_comb
        begin
                for (int k = 0; k < 3; k++)
                begin
                        drop[k] = prevValid[k] & (|(prevPkt[k].branchMask & modelKill));
                        pass[k] = prevValid[k] & ~drop[k];
                end
        end

        // ------------------------------------------------------------------------
        // Properties
        // ------------------------------------------------------------------------
        assert property (@(posedge clk) resetSeen |-> !(wbValid0_o | wbValid1_o | wbValid2_o
                        | bypassValid0_o | bypassValid1_o | bypassValid2_o | ctrlVerified_o
                        | ctrlMispredict_o | flushActive_o))
                else
                begin
                        $error("ERROR %0t: outputs active right after reset", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset) pass[0] |-> wbValid0_o
                        && wbTag0_o == prevPkt[0].alTag
                        && bypassValid0_o == prevPkt[0].flags.writesReg
                        && (!bypassValid0_o || (bypassDest0_o == prevPkt[0].physDest
                        && bypassData0_o == prevPkt[0].payload.data)))
                else
                begin
                        $error("ERROR %0t: lane 0 writeback mismatch", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset) pass[1] |-> wbValid1_o
                        && wbTag1_o == prevPkt[1].alTag
                        && bypassValid1_o == prevPkt[1].flags.writesReg
                        && (!bypassValid1_o || (bypassDest1_o == prevPkt[1].physDest
                        && bypassData1_o == prevPkt[1].payload.data)))
                else
                begin
                        $error("ERROR %0t: lane 1 writeback mismatch", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset) pass[2] |-> wbValid2_o
                        && wbTag2_o == prevPkt[2].alTag
                        && bypassValid2_o == prevPkt[2].flags.writesReg
                        && (!bypassValid2_o || (bypassDest2_o == prevPkt[2].physDest
                        && bypassData2_o == prevPkt[2].payload.data)))
                else
                begin
                        $error("ERROR %0t: lane 2 writeback mismatch", $time);
                        errorCount++;
                end

        // No packet, or a flushed one, leaves no trace
        assert property (@(posedge clk) disable iff (reset)
                        !pass[0] |-> !wbValid0_o && !bypassValid0_o)
                else
                begin
                        $error("ERROR %0t: lane 0 writeback for a missing or killed packet", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset)
                        !pass[1] |-> !wbValid1_o && !bypassValid1_o)
                else
                begin
                        $error("ERROR %0t: lane 1 writeback for a missing or killed packet", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset)
                        !pass[2] |-> !wbValid2_o && !bypassValid2_o)
                else
                begin
                        $error("ERROR %0t: lane 2 writeback for a missing or killed packet", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset)
                        (prevValid[1] && prevPkt[1].flags.isBranch) |-> ctrlVerified_o
                        && ctrlMispredict_o == (prevCtrl.actualTaken ^ prevCtrl.predTaken)
                        && ctrlCheckpoint_o == prevCtrl.checkpointId
                        && ctrlTarget_o == prevCtrl.target
                        && ctrlTaken_o == prevCtrl.actualTaken)
                else
                begin
                        $error("ERROR %0t: branch resolution mismatch", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset)
                        !(prevValid[1] && prevPkt[1].flags.isBranch) |-> !ctrlVerified_o
                        && !ctrlMispredict_o)
                else
                begin
                        $error("ERROR %0t: resolution without a branch", $time);
                        errorCount++;
                end

        assert property (@(posedge clk) disable iff (reset) flushActive_o == (modelCount != 0))
                else
                begin
                        $error("ERROR %0t: flush window length wrong", $time);
                        errorCount++;
                end

endmodule

//--- bench/tbWriteback.sv
module tbWriteback import wbPkg::*;
();

        localparam int FLUSH_CYCLES  = 4;
        localparam int RESET_CYCLES  = 3;
        localparam int RANDOM_CYCLES = 400;
        localparam int DIRECT_CYCLES = 40;
        localparam int WATCHDOG_TIME = (RESET_CYCLES + RANDOM_CYCLES + DIRECT_CYCLES + 50) * 10;

        logic                       clk;
        logic                       reset;
        logic                       exeValid0_i;
        logic                       exeValid1_i;
        logic                       exeValid2_i;
        exePacket_t                 exePacket0_i;
        exePacket_t                 exePacket1_i;
        exePacket_t                 exePacket2_i;
        logic                       wbValid0_o;
        logic                       wbValid1_o;
        logic                       wbValid2_o;
        logic [AL_LOG-1:0]          wbTag0_o;
        logic [AL_LOG-1:0]          wbTag1_o;
        logic [AL_LOG-1:0]          wbTag2_o;
        logic                       bypassValid0_o;
        logic                       bypassValid1_o;
        logic                       bypassValid2_o;
        logic [PHYS_LOG-1:0]        bypassDest0_o;
        logic [PHYS_LOG-1:0]        bypassDest1_o;
        logic [PHYS_LOG-1:0]        bypassDest2_o;
        logic [DATA_WIDTH-1:0]      bypassData0_o;
        logic [DATA_WIDTH-1:0]      bypassData1_o;
        logic [DATA_WIDTH-1:0]      bypassData2_o;
        logic                       ctrlVerified_o;
        logic                       ctrlMispredict_o;
        logic [CHECKPOINTS_LOG-1:0] ctrlCheckpoint_o;
        logic [PC_WIDTH-1:0]        ctrlTarget_o;
        logic                       ctrlTaken_o;
        logic                       flushActive_o;
        logic [31:0]                lcgState;

        writebackStage #(.FLUSH_CYCLES (FLUSH_CYCLES)) u_writebackStage (.*);

        bind writebackStage writebackStage_assert #(.FLUSH_CYCLES (FLUSH_CYCLES)) uAssert (.*);

        always #5 clk = ~clk;

        // ------------------------------------------------------------------------
        // Stimulus helpers
        // ------------------------------------------------------------------------
        function automatic logic [31:0] nextRand();
                lcgState = lcgState * 32'd1103515245 + 32'd12345;
                return {lcgState[31:16], lcgState[15:0] ^ lcgState[31:16]};
        endfunction

        function automatic exePacket_t plainPacket(logic [CHECKPOINTS-1:0] mask);
                exePacket_t pkt;
                pkt.branchMask      = mask;
                pkt.flags.writesReg = nextRand() & 1;
                pkt.flags.isBranch  = 1'b0;
                pkt.alTag           = nextRand();
                pkt.physDest        = nextRand();
                pkt.payload.data    = nextRand();
                return pkt;
        endfunction

        // Mask never holds the branch's own checkpoint
        function automatic exePacket_t branchPacket(logic [CHECKPOINTS-1:0] mask,
                        logic [CHECKPOINTS_LOG-1:0] id, logic wrong);
                exePacket_t pkt;
                ctrlView_t  view;
                pkt = plainPacket(mask & ~(CHECKPOINTS'(1) << id));
                pkt.flags.isBranch = 1'b1;
                view.target        = nextRand();
                view.actualTaken   = nextRand() & 1;
                view.predTaken     = view.actualTaken ^ wrong;
                view.checkpointId  = id;
                view.spare         = '0;
                pkt.payload.ctrl   = view;
                return pkt;
        endfunction

        task automatic randomCycle();
                logic [CHECKPOINTS-1:0] mask0;
                logic [CHECKPOINTS-1:0] mask1;
                logic [CHECKPOINTS-1:0] mask2;
                @(negedge clk);
                mask0 = nextRand() & nextRand();               // Sparse masks
                mask1 = nextRand() & nextRand();
                mask2 = nextRand() & nextRand();
                exeValid0_i  = nextRand() & 1;
                exeValid1_i  = nextRand() & 1;
                exeValid2_i  = nextRand() & 1;
                exePacket0_i = plainPacket(mask0);
                exePacket2_i = plainPacket(mask2);
                if (nextRand() & 1)
                        exePacket1_i = branchPacket(mask1, nextRand(), (nextRand() & 3) == 0);
                else
                        exePacket1_i = plainPacket(mask1);
        endtask

        // One cycle with chosen masks and an optional lane 1 branch
        task automatic directCycle(logic [CHECKPOINTS-1:0] mask, logic doBranch,
                        logic [CHECKPOINTS_LOG-1:0] id, logic wrong);
                @(negedge clk);
                exeValid0_i  = 1'b1;
                exeValid1_i  = 1'b1;
                exeValid2_i  = 1'b1;
                exePacket0_i = plainPacket(mask);
                exePacket2_i = plainPacket(mask);
                if (doBranch)
                        exePacket1_i = branchPacket('0, id, wrong);
                else
                        exePacket1_i = plainPacket(mask);
        endtask

        task automatic abortRun(string msg);
                $display("ERROR %0t: %s", $time, msg);
                $display("Testbench failed");
                $fatal(1);
        endtask

        task automatic expectIdle();
                if (flushActive_o !== 1'b0)
                        abortRun("flush window still open after quiet period");
        endtask

        // Stop at the first failed assertion
        always @(negedge clk)
        begin
                if (u_writebackStage.uAssert.errorCount != 0)
                        abortRun("assertion check failed");
        end

        // ------------------------------------------------------------------------
        // Main sequence
        // ------------------------------------------------------------------------
        initial
        begin
                lcgState     = 32'd73;
                clk          = 1'b0;
                reset        = 1'b1;
                exeValid0_i  = 1'b0;
                exeValid1_i  = 1'b0;
                exeValid2_i  = 1'b0;
                exePacket0_i = '0;
                exePacket1_i = '0;
                exePacket2_i = '0;
                repeat (RESET_CYCLES) @(negedge clk);
                reset = 1'b0;

                for (int i = 0; i < RANDOM_CYCLES; i++)
                        randomCycle();

                // Isolated mispredict on checkpoint 2, flushed packets follow
                directCycle(8'h00, 1'b0, 3'd0, 1'b0);
                repeat (FLUSH_CYCLES + 2) directCycle(8'h00, 1'b0, 3'd0, 1'b0);
                directCycle(8'h04, 1'b1, 3'd2, 1'b1);
                repeat (FLUSH_CYCLES + 3) directCycle(8'h04, 1'b0, 3'd0, 1'b0);

                // Back to back mispredicts
                directCycle(8'h28, 1'b1, 3'd3, 1'b1);
                directCycle(8'h28, 1'b1, 3'd5, 1'b1);
                repeat (FLUSH_CYCLES + 2) directCycle(8'h08, 1'b0, 3'd0, 1'b0);    // Older bit alone

                // Second mispredict inside the window
                directCycle(8'h42, 1'b1, 3'd1, 1'b1);
                directCycle(8'h42, 1'b0, 3'd0, 1'b0);
                directCycle(8'h42, 1'b1, 3'd6, 1'b1);
                repeat (FLUSH_CYCLES + 3) directCycle(8'h02, 1'b0, 3'd0, 1'b0);    // Older bit alone

                @(negedge clk);
                exeValid0_i = 1'b0;
                exeValid1_i = 1'b0;
                exeValid2_i = 1'b0;
                repeat (2) @(negedge clk);
                expectIdle();
                if (u_writebackStage.uAssert.errorCount != 0)
                        abortRun("assertion failures were recorded");
                else
                begin
                        $display("Testbench passed");
                        $finish;
                end
        end

        initial
        begin
                #(WATCHDOG_TIME);
                $display("Watchdog expired before the stimulus finished");
                $display("Testbench failed");
                $fatal(1);
        end

endmodule

//--- src.f
logic/wbPkg.sv
logic/wbIfs.sv
logic/flushTimer.sv
logic/recoveryCtrl.sv
logic/branchResolve.sv
logic/wbLane.sv
logic/writebackStage.sv
bench/writebackStage_assert.sv
bench/tbWriteback.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message

verilator --binary --timing --assert -Wno-fatal \
        -f src.f --top-module tbWriteback -o simWriteback &&
./obj_dir/simWriteback | tee /dev/stderr | grep -q "Testbench passed" &&
echo "run.sh: simulation passed" ||
{
        echo "run.sh: simulation failed"
        exit 1
}
